// ==== common/ipod_params.svh ====
`ifndef IPOD_PARAMS_SVH
`define IPOD_PARAMS_SVH

// ================================================
// Flash geometry
// ================================================
`define IPOD_FLASH_AW 23
`define IPOD_FLASH_DW 32
`define IPOD_SAMPLE_W 8

// Last word of the audio region
`define IPOD_END_ADDR 23'h7FFFF

// ================================================
// Sample rate, in CLK_50M cycles per sample
// ================================================
`define IPOD_DIV_W 16
`define IPOD_DIV_DEFAULT 4545
`define IPOD_DIV_STEP 100
`define IPOD_DIV_MIN 1000
`define IPOD_DIV_MAX 9000

`endif

// ==== common/ipod_pkg.sv ====
`include "ipod_params.svh"

package ipod_pkg;

  // One flash word address and its contents
  typedef logic [`IPOD_FLASH_AW-1:0] flash_addr_t;
  typedef logic [`IPOD_FLASH_DW-1:0] flash_word_t;

  // Word address in the upper bits, half select in bit 0
  typedef logic [`IPOD_FLASH_AW:0] sample_idx_t;

  // Signed byte sent to the audio path
  typedef logic signed [`IPOD_SAMPLE_W-1:0] sample_t;

  // Tick period in clock cycles
  typedef logic [`IPOD_DIV_W-1:0] div_t;

  // Decoded keyboard commands
  typedef enum logic [2:0] {
    CMD_NONE,
    CMD_PLAY,
    CMD_PAUSE,
    CMD_FWD,
    CMD_BWD,
    CMD_RESTART
  } kbd_cmd_t;

endpackage

// ==== playback/playback_ctrl.sv ====
`timescale 1ns/1ps

module playback_ctrl (
  input  logic       CLK_50M,
  input  logic       rst,
  input  logic [7:0] kbd_ascii,
  input  logic       kbd_valid,
  input  logic       tick,
  input  logic       rd_done,
  output logic       rd_req,
  output logic       load,
  output logic       step,
  output logic       restart,
  output logic       restart_dir,
  output logic       dir,
  output logic       playing,
  output logic       forward
);

  // Upper case keys only
  localparam logic [7:0] ASCII_B = 8'h42;
  localparam logic [7:0] ASCII_D = 8'h44;
  localparam logic [7:0] ASCII_E = 8'h45;
  localparam logic [7:0] ASCII_F = 8'h46;
  localparam logic [7:0] ASCII_R = 8'h52;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FETCH,
    ST_DELIVER
  } state_t;

  state_t             state;
  ipod_pkg::kbd_cmd_t cmd;

  // ================================================
  // Command decode
  // ================================================
  always_comb
  begin
    cmd = ipod_pkg::CMD_NONE;
    if (kbd_valid)
    begin
      case (kbd_ascii)
        ASCII_E: cmd = ipod_pkg::CMD_PLAY;
        ASCII_D: cmd = ipod_pkg::CMD_PAUSE;
        ASCII_F: cmd = ipod_pkg::CMD_FWD;
        ASCII_B: cmd = ipod_pkg::CMD_BWD;
        ASCII_R: cmd = ipod_pkg::CMD_RESTART;
        default: cmd = ipod_pkg::CMD_NONE;
      endcase
    end
  end

  // Play and direction flags, restart pulse
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      playing     <= 1'b0;
      forward     <= 1'b1;
      restart     <= 1'b0;
      restart_dir <= 1'b1;
    end
    else
    begin
      restart <= 1'b0;
      case (cmd)
        ipod_pkg::CMD_PLAY:  playing <= 1'b1;
        ipod_pkg::CMD_PAUSE: playing <= 1'b0;
        ipod_pkg::CMD_FWD:   forward <= 1'b1;
        ipod_pkg::CMD_BWD:   forward <= 1'b0;
        ipod_pkg::CMD_RESTART:
        begin
          restart     <= 1'b1;
          restart_dir <= forward;
        end
        default: ;
      endcase
    end
  end

  assign dir = forward;

  // ================================================
  // Per-tick sequence
  // ================================================
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      state  <= ST_IDLE;
      rd_req <= 1'b0;
      load   <= 1'b0;
      step   <= 1'b0;
    end
    else
    begin
      rd_req <= 1'b0;
      load   <= 1'b0;
      step   <= 1'b0;
      case (state)
        ST_IDLE:
        begin
          // Ticks outside idle are simply lost
          if (tick && playing)
          begin
            rd_req <= 1'b1;
            state  <= ST_FETCH;
          end
        end
        ST_FETCH:
        begin
          if (rd_done)
          begin
            load  <= 1'b1;
            step  <= 1'b1;
            state <= ST_DELIVER;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Reader answers only our own requests
  done_only_in_fetch: assert property (@(posedge CLK_50M) disable iff (rst)
    rd_done |-> state == ST_FETCH);

endmodule

// ==== playback/rate_gen.sv ====
`timescale 1ns/1ps
`include "ipod_params.svh"

module rate_gen (
  input  logic CLK_50M,
  input  logic rst,
  input  logic faster,
  input  logic slower,
  input  logic speed_reset,
  output logic tick
);

  ipod_pkg::div_t div;
  ipod_pkg::div_t div_next;
  ipod_pkg::div_t cnt;
  logic           speed_change;

  assign speed_change = faster | slower | speed_reset;

  // Speed reset first, then faster, then slower
  always_comb
  begin
    div_next = div;
    if (speed_reset)
      div_next = `IPOD_DIV_DEFAULT;
    else if (faster)
    begin
      if (div < `IPOD_DIV_MIN + `IPOD_DIV_STEP)
        div_next = `IPOD_DIV_MIN;
      else
        div_next = div - `IPOD_DIV_STEP;
    end
    else if (slower)
    begin
      if (div > `IPOD_DIV_MAX - `IPOD_DIV_STEP)
        div_next = `IPOD_DIV_MAX;
      else
        div_next = div + `IPOD_DIV_STEP;
    end
  end

  // Down-counter, one tick per div cycles
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      div  <= `IPOD_DIV_DEFAULT;
      cnt  <= `IPOD_DIV_DEFAULT - 1;
      tick <= 1'b0;
    end
    else if (speed_change)
    begin
      div  <= div_next;
      cnt  <= div_next - 1'b1;
      tick <= 1'b0;
    end
    else if (cnt == '0)
    begin
      cnt  <= div - 1'b1;
      tick <= 1'b1;
    end
    else
    begin
      cnt  <= cnt - 1'b1;
      tick <= 1'b0;
    end
  end

  div_in_range: assert property (@(posedge CLK_50M) disable iff (rst)
    (div >= `IPOD_DIV_MIN) && (div <= `IPOD_DIV_MAX));

endmodule

// ==== playback/addr_seq.sv ====
`timescale 1ns/1ps
`include "ipod_params.svh"

module addr_seq (
  input  logic                  CLK_50M,
  input  logic                  rst,
  input  logic                  step,
  input  logic                  dir,
  input  logic                  restart,
  input  logic                  restart_dir,
  output ipod_pkg::sample_idx_t sample_idx
);

  // Upper half of the last word in the region
  localparam ipod_pkg::sample_idx_t LAST_IDX = {`IPOD_END_ADDR, 1'b1};

  ipod_pkg::sample_idx_t idx_up;
  ipod_pkg::sample_idx_t idx_down;

  // Neighbours with wrap at both ends
  always_comb
  begin
    if (sample_idx == LAST_IDX)
      idx_up = '0;
    else
      idx_up = sample_idx + 1'b1;

    if (sample_idx == '0)
      idx_down = LAST_IDX;
    else
      idx_down = sample_idx - 1'b1;
  end

  // ================================================
  // Index register
  // ================================================
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      sample_idx <= '0;
    else if (restart)
    begin
      // Forward restarts at the start, backward at the end
      sample_idx <= restart_dir ? '0 : LAST_IDX;
    end
    else if (step)
    begin
      sample_idx <= dir ? idx_up : idx_down;
    end
  end

  idx_in_region: assert property (@(posedge CLK_50M) disable iff (rst)
    sample_idx <= LAST_IDX);

endmodule

// ==== playback/flash_reader.sv ====
`timescale 1ns/1ps

module flash_reader (
  input  logic                  CLK_50M,
  input  logic                  rst,
  input  logic                  rd_req,
  input  ipod_pkg::flash_addr_t word_addr,
  input  ipod_pkg::flash_word_t wb_dat_i,
  input  logic                  wb_ack,
  output logic                  wb_cyc,
  output logic                  wb_stb,
  output ipod_pkg::flash_addr_t wb_adr,
  output ipod_pkg::flash_word_t rd_data,
  output logic                  rd_done
);

  // One classic cycle at a time
  logic busy;

  // ================================================
  // Bus cycle control
  // ================================================
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      busy    <= 1'b0;
      rd_done <= 1'b0;
    end
    else
    begin
      rd_done <= 1'b0;
      if (busy)
      begin
        if (wb_ack)
        begin
          busy    <= 1'b0;
          rd_done <= 1'b1;
        end
      end
      else if (rd_req)
      begin
        busy <= 1'b1;
      end
    end
  end

  assign wb_cyc = busy;
  assign wb_stb = busy;

  // Address latched at request time
  always_ff @(posedge CLK_50M)
  begin
    if (!busy && rd_req)
      wb_adr <= word_addr;
  end

  // Read data taken in the ack cycle
  always_ff @(posedge CLK_50M)
  begin
    if (busy && wb_ack)
      rd_data <= wb_dat_i;
  end

  // Request held with a steady address until the slave answers
  adr_stable: assert property (@(posedge CLK_50M) disable iff (rst)
    wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr));

endmodule

// ==== playback/sample_unpack.sv ====
`timescale 1ns/1ps
`include "ipod_params.svh"

module sample_unpack (
  input  logic                  CLK_50M,
  input  logic                  rst,
  input  logic                  load,
  input  ipod_pkg::flash_word_t rd_data,
  input  logic                  half,
  output ipod_pkg::sample_t     audio_sample,
  output logic                  audio_valid
);

  localparam int HALF_W = `IPOD_FLASH_DW / 2;

  logic [HALF_W-1:0] chosen;

  // Lower half plays first
  assign chosen = half ? rd_data[`IPOD_FLASH_DW-1 -: HALF_W] : rd_data[HALF_W-1:0];

  // Keep the top byte of the 16-bit sample
  always_ff @(posedge CLK_50M)
  begin
    if (load)
      audio_sample <= ipod_pkg::sample_t'(chosen[HALF_W-1 -: `IPOD_SAMPLE_W]);
  end

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      audio_valid <= 1'b0;
    else
      audio_valid <= load;
  end

endmodule

// ==== verilog/simple_ipod.sv ====
`timescale 1ns/1ps
`include "ipod_params.svh"

module simple_ipod (
  input  logic                  CLK_50M,
  input  logic                  rst,
  input  logic [7:0]            kbd_ascii,
  input  logic                  kbd_valid,
  input  logic                  faster,
  input  logic                  slower,
  input  logic                  speed_reset,
  output ipod_pkg::sample_t     audio_sample,
  output logic                  audio_valid,
  output logic                  playing,
  output logic                  forward,
  output logic                  wb_cyc,
  output logic                  wb_stb,
  output ipod_pkg::flash_addr_t wb_adr,
  input  ipod_pkg::flash_word_t wb_dat_i,
  input  logic                  wb_ack
);

  logic                  tick;
  logic                  rd_req;
  logic                  rd_done;
  logic                  load;
  logic                  step;
  logic                  dir;
  logic                  restart;
  logic                  restart_dir;
  ipod_pkg::flash_word_t rd_data;
  ipod_pkg::sample_idx_t sample_idx;

  // ================================================
  // Control
  // ================================================
  playback_ctrl u_ctrl (
    .CLK_50M     (CLK_50M),
    .rst         (rst),
    .kbd_ascii   (kbd_ascii),
    .kbd_valid   (kbd_valid),
    .tick        (tick),
    .rd_done     (rd_done),
    .rd_req      (rd_req),
    .load        (load),
    .step        (step),
    .restart     (restart),
    .restart_dir (restart_dir),
    .dir         (dir),
    .playing     (playing),
    .forward     (forward)
  );

  // ================================================
  // Datapath
  // ================================================
  rate_gen u_rate (
    .CLK_50M     (CLK_50M),
    .rst         (rst),
    .faster      (faster),
    .slower      (slower),
    .speed_reset (speed_reset),
    .tick        (tick)
  );

  addr_seq u_addr (
    .CLK_50M     (CLK_50M),
    .rst         (rst),
    .step        (step),
    .dir         (dir),
    .restart     (restart),
    .restart_dir (restart_dir),
    .sample_idx  (sample_idx)
  );

  // Word part of the index addresses the flash
  flash_reader u_reader (
    .CLK_50M   (CLK_50M),
    .rst       (rst),
    .rd_req    (rd_req),
    .word_addr (sample_idx[`IPOD_FLASH_AW:1]),
    .wb_dat_i  (wb_dat_i),
    .wb_ack    (wb_ack),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_adr    (wb_adr),
    .rd_data   (rd_data),
    .rd_done   (rd_done)
  );

  sample_unpack u_unpack (
    .CLK_50M      (CLK_50M),
    .rst          (rst),
    .load         (load),
    .rd_data      (rd_data),
    .half         (sample_idx[0]),
    .audio_sample (audio_sample),
    .audio_valid  (audio_valid)
  );

endmodule

// ==== sim/wb_flash_model.sv ====
`timescale 1ns/1ps
`include "ipod_params.svh"

module wb_flash_model (
  input  logic                  CLK_50M,
  input  logic                  rst,
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  ipod_pkg::flash_addr_t wb_adr,
  output ipod_pkg::flash_word_t wb_dat,
  output logic                  wb_ack
);

  integer      seed = 32'h7487;
  logic        pending;
  int unsigned wait_left;
  int unsigned remaining;

  // Address, its inverse and a fixed pattern, spread over all four bytes
  function automatic ipod_pkg::flash_word_t flash_word(input ipod_pkg::flash_addr_t a);
    return {a[7:0], ~a[15:8], ~a[7:0] ^ a[`IPOD_FLASH_AW-1 -: 8], a[`IPOD_FLASH_AW-1 -: 8]}
           ^ 32'hC300_005A;
  endfunction

  // ================================================
  // Classic slave, 0 to 5 wait cycles per access
  // ================================================
  always @(posedge CLK_50M)
  begin
    if (rst)
    begin
      wb_ack    <= 1'b0;
      wb_dat    <= '0;
      pending   <= 1'b0;
      wait_left <= 0;
    end
    else if (wb_ack)
      wb_ack <= 1'b0;
    else if (wb_cyc && wb_stb)
    begin
      // New access draws its own latency
      if (pending)
        remaining = wait_left;
      else
        remaining = {$random(seed)} % 6;
      if (remaining == 0)
      begin
        wb_ack  <= 1'b1;
        wb_dat  <= flash_word(wb_adr);
        pending <= 1'b0;
      end
      else
      begin
        pending   <= 1'b1;
        wait_left <= remaining - 1;
      end
    end
  end

endmodule

// ==== sim/tb_simple_ipod.sv ====
`timescale 1ns/1ps
`include "ipod_params.svh"

module tb_simple_ipod;

  localparam int DIV_DEF = `IPOD_DIV_DEFAULT;
  localparam ipod_pkg::sample_idx_t LAST_IDX = {`IPOD_END_ADDR, 1'b1};

  localparam logic [7:0] KEY_B = 8'h42;
  localparam logic [7:0] KEY_D = 8'h44;
  localparam logic [7:0] KEY_E = 8'h45;
  localparam logic [7:0] KEY_F = 8'h46;
  localparam logic [7:0] KEY_R = 8'h52;
  localparam logic [7:0] KEY_X = 8'h58;

  logic                  CLK_50M;
  logic                  rst;
  logic [7:0]            kbd_ascii;
  logic                  kbd_valid;
  logic                  faster;
  logic                  slower;
  logic                  speed_reset;
  ipod_pkg::sample_t     audio_sample;
  logic                  audio_valid;
  logic                  playing;
  logic                  forward;
  logic                  wb_cyc;
  logic                  wb_stb;
  ipod_pkg::flash_addr_t wb_adr;
  ipod_pkg::flash_word_t wb_dat_i;
  logic                  wb_ack;

  // Reference state and counters
  ipod_pkg::sample_idx_t model_idx;
  logic                  model_fwd;
  logic                  cyc_prev;
  int                    errors;
  int                    timeouts;
  int                    sample_count;
  int                    cyc_starts;
  int                    cyc_count;
  int                    last_cyc_start;
  int                    cyc_gap;
  int                    held_count;

  simple_ipod uut (
    .CLK_50M      (CLK_50M),
    .rst          (rst),
    .kbd_ascii    (kbd_ascii),
    .kbd_valid    (kbd_valid),
    .faster       (faster),
    .slower       (slower),
    .speed_reset  (speed_reset),
    .audio_sample (audio_sample),
    .audio_valid  (audio_valid),
    .playing      (playing),
    .forward      (forward),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_adr       (wb_adr),
    .wb_dat_i     (wb_dat_i),
    .wb_ack       (wb_ack)
  );

  wb_flash_model flash (
    .CLK_50M (CLK_50M),
    .rst     (rst),
    .wb_cyc  (wb_cyc),
    .wb_stb  (wb_stb),
    .wb_adr  (wb_adr),
    .wb_dat  (wb_dat_i),
    .wb_ack  (wb_ack)
  );

  // Lower half first, top byte of the 16-bit sample
  function automatic ipod_pkg::sample_t expected_sample(input ipod_pkg::sample_idx_t idx);
    ipod_pkg::flash_word_t w;
    logic [15:0]           pcm;
    w   = flash.flash_word(idx[`IPOD_FLASH_AW:1]);
    pcm = idx[0] ? w[31:16] : w[15:0];
    return pcm[15:8];
  endfunction

  // Step with wrap at both ends of the region
  function automatic ipod_pkg::sample_idx_t next_idx(input ipod_pkg::sample_idx_t idx,
                                                     input logic fwd);
    if (fwd)
      return (idx == LAST_IDX) ? '0 : idx + 1'b1;
    return (idx == '0) ? LAST_IDX : idx - 1'b1;
  endfunction

  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  // ================================================
  // Comparison process
  // ================================================
  always @(posedge CLK_50M)
  begin
    if (rst)
    begin
      sample_count   = 0;
      cyc_starts     = 0;
      cyc_count      = 0;
      last_cyc_start = 0;
      cyc_gap        = 0;
      cyc_prev       = 1'b0;
    end
    else
    begin
      cyc_count = cyc_count + 1;
      // Classic read raises and drops stb together with cyc
      if (wb_stb !== wb_cyc)
      begin
        errors = errors + 1;
        $display("[FAIL] wb_stb: got %h, expected %h", wb_stb, wb_cyc);
      end
      // Each bus cycle start marks one sample tick
      if (wb_cyc && !cyc_prev)
      begin
        // Word part of the index about to play
        if (wb_adr !== model_idx[`IPOD_FLASH_AW:1])
        begin
          errors = errors + 1;
          $display("[FAIL] wb_adr: got %h, expected %h",
                   wb_adr, model_idx[`IPOD_FLASH_AW:1]);
        end
        if (cyc_starts > 0)
          cyc_gap = cyc_count - last_cyc_start;
        last_cyc_start = cyc_count;
        cyc_starts     = cyc_starts + 1;
      end
      cyc_prev = wb_cyc;
      if (audio_valid)
      begin
        if (audio_sample !== expected_sample(model_idx))
        begin
          errors = errors + 1;
          $display("[FAIL] audio_sample: got %h, expected %h at index %h",
                   audio_sample, expected_sample(model_idx), model_idx);
        end
        sample_count = sample_count + 1;
        model_idx    = next_idx(model_idx, model_fwd);
      end
    end
  end

  // ================================================
  // Stimulus tasks
  // ================================================
  task automatic apply_reset();
    @(negedge CLK_50M);
    rst = 1'b1;
    repeat (8) @(negedge CLK_50M);
    rst       = 1'b0;
    model_idx = '0;
    model_fwd = 1'b1;
  endtask

  task automatic send_key(input logic [7:0] key);
    @(negedge CLK_50M);
    kbd_ascii = key;
    kbd_valid = 1'b1;
    @(negedge CLK_50M);
    kbd_valid = 1'b0;
    case (key)
      KEY_F: model_fwd = 1'b1;
      KEY_B: model_fwd = 1'b0;
      KEY_R: model_idx = model_fwd ? '0 : LAST_IDX;
      default: ;
    endcase
  endtask

  // 0 faster, 1 slower, 2 speed reset
  task automatic pulse_speed(input int sel);
    @(negedge CLK_50M);
    faster      = (sel == 0);
    slower      = (sel == 1);
    speed_reset = (sel == 2);
    @(negedge CLK_50M);
    faster      = 1'b0;
    slower      = 1'b0;
    speed_reset = 1'b0;
  endtask

  // Let a fetch already on the bus deliver its sample
  task automatic let_fetch_finish();
    repeat (32) @(negedge CLK_50M);
  endtask

  task automatic wait_samples(input int n);
    int target;
    int waited;
    target = sample_count + n;
    waited = 0;
    while (sample_count < target && waited < (n + 2) * `IPOD_DIV_MAX)
    begin
      @(negedge CLK_50M);
      waited = waited + 1;
    end
    if (sample_count < target)
    begin
      timeouts = timeouts + 1;
      $display("Timeout: only %0d of %0d audio samples arrived", n - (target - sample_count), n);
    end
  endtask

  task automatic wait_cyc_starts(input int n);
    int target;
    int waited;
    target = cyc_starts + n;
    waited = 0;
    while (cyc_starts < target && waited < (n + 2) * `IPOD_DIV_MAX)
    begin
      @(negedge CLK_50M);
      waited = waited + 1;
    end
    if (cyc_starts < target)
    begin
      timeouts = timeouts + 1;
      $display("Timeout: flash reads stopped while waiting for %0d bus cycles", n);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      errors = errors + 1;
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // First gap after a change may straddle the old period
  task automatic check_rate(input int expected);
    wait_cyc_starts(3);
    if (cyc_gap != expected)
    begin
      errors = errors + 1;
      $display("[FAIL] tick period: got %h, expected %h", cyc_gap, expected);
    end
  endtask

  // ================================================
  // Main sequence
  // ================================================
  initial
  begin
    rst         = 1'b1;
    kbd_ascii   = 8'h00;
    kbd_valid   = 1'b0;
    faster      = 1'b0;
    slower      = 1'b0;
    speed_reset = 1'b0;
    errors      = 0;
    timeouts    = 0;
    model_idx   = '0;
    model_fwd   = 1'b1;
    apply_reset();

    // Idle after reset
    check_bit("playing", playing, 1'b0);
    check_bit("forward", forward, 1'b1);
    repeat (3 * DIV_DEF) @(negedge CLK_50M);
    if (cyc_starts != 0 || sample_count != 0)
    begin
      errors = errors + 1;
      $display("Flash read or audio sample appeared before playback was started");
    end

    // Play from index 0
    send_key(KEY_E);
    check_bit("playing", playing, 1'b1);
    wait_samples(20);

    // Pause, ignored byte, resume
    send_key(KEY_D);
    let_fetch_finish();
    held_count = sample_count;
    repeat (2 * DIV_DEF) @(negedge CLK_50M);
    if (sample_count != held_count)
    begin
      errors = errors + 1;
      $display("Audio sample delivered while playback was paused");
    end
    send_key(KEY_X);
    check_bit("playing", playing, 1'b0);
    check_bit("forward", forward, 1'b1);
    send_key(KEY_E);
    wait_samples(3);

    // Backward restart from the last index
    send_key(KEY_D);
    let_fetch_finish();
    send_key(KEY_B);
    send_key(KEY_R);
    check_bit("forward", forward, 1'b0);
    send_key(KEY_E);
    wait_samples(5);

    // Backward wrap through index 0
    apply_reset();
    send_key(KEY_B);
    send_key(KEY_E);
    wait_samples(3);
    check_bit("forward", forward, 1'b0);

    // Speed control and clamping
    repeat (3) pulse_speed(0);
    check_rate(DIV_DEF - 3 * `IPOD_DIV_STEP);
    pulse_speed(2);
    check_rate(DIV_DEF);
    repeat (50) pulse_speed(1);
    check_rate(`IPOD_DIV_MAX);
    pulse_speed(2);

    // Forward again from the current index
    send_key(KEY_D);
    let_fetch_finish();
    send_key(KEY_F);
    check_bit("forward", forward, 1'b1);
    send_key(KEY_E);
    wait_samples(5);

    $display("Samples checked %0d, errors %0d, timeouts %0d", sample_count, errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+common
common/ipod_pkg.sv
playback/playback_ctrl.sv
playback/rate_gen.sv
playback/addr_seq.sv
playback/flash_reader.sv
playback/sample_unpack.sv
verilog/simple_ipod.sv
sim/wb_flash_model.sv
sim/tb_simple_ipod.sv

// ==== Bender.yml ====
package:
  name: simple_ipod

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/ipod_pkg.sv
      - playback/playback_ctrl.sv
      - playback/rate_gen.sv
      - playback/addr_seq.sv
      - playback/flash_reader.sv
      - playback/sample_unpack.sv
      - verilog/simple_ipod.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/wb_flash_model.sv
      - sim/tb_simple_ipod.sv
